//--- Makefile
TOP = apb_gpio_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- include/gpio_cfg.svh
`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

`define GPIO_PAD_NUM        32
`define GPIO_APB_ADDR_WIDTH 12   // 4 KB slave window
`define GPIO_DATA_WIDTH     32

// Word indices, matched against PADDR[6:2]
`define GPIO_REG_PADDIR      5'd0
`define GPIO_REG_GPIOEN      5'd1
`define GPIO_REG_PADIN       5'd2
`define GPIO_REG_PADOUT      5'd3
`define GPIO_REG_PADOUTSET   5'd4
`define GPIO_REG_PADOUTCLR   5'd5
`define GPIO_REG_INTEN       5'd6
`define GPIO_REG_INTTYPE_LO  5'd7   // Pads 0 to 15
`define GPIO_REG_INTTYPE_HI  5'd8   // Pads 16 to 31
`define GPIO_REG_INTSTATUS   5'd9

`endif

//--- logic/apb_gpio.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_cfg.svh"

module apb_gpio
    import gpio_pkg::*;
(
    input  logic                            HCLK,
    input  logic                            HRESETn,

    input  logic [`GPIO_APB_ADDR_WIDTH-1:0] PADDR,
    input  logic [`GPIO_DATA_WIDTH-1:0]     PWDATA,
    input  logic                            PWRITE,
    input  logic                            PSEL,
    input  logic                            PENABLE,
    output logic [`GPIO_DATA_WIDTH-1:0]     PRDATA,
    output logic                            PREADY,
    output logic                            PSLVERR,

    input  pad_vec_t                        gpio_in,
    output pad_vec_t                        gpio_in_sync,
    output pad_vec_t                        gpio_out,
    output pad_vec_t                        gpio_dir,
    output logic                            interrupt
);

    pad_vec_t sync_in;
    pad_vec_t prev_in;

    gpio_irq_if irq_bus ();

    gpio_input_sync gpio_input_sync_inst (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .gpio_in (gpio_in),
        .sync_in (sync_in),
        .prev_in (prev_in)
    );

    gpio_irq_unit gpio_irq_unit_inst (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .sync_in   (sync_in),
        .prev_in   (prev_in),
        .irq       (irq_bus.irq),
        .interrupt (interrupt)
    );

    gpio_apb_regs gpio_apb_regs_inst (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .PADDR    (PADDR),
        .PWDATA   (PWDATA),
        .PWRITE   (PWRITE),
        .PSEL     (PSEL),
        .PENABLE  (PENABLE),
        .PRDATA   (PRDATA),
        .padin    (prev_in),   // PADIN is the oldest sample
        .gpio_out (gpio_out),
        .gpio_dir (gpio_dir),
        .irq      (irq_bus.regs)
    );

    assign gpio_in_sync = sync_in;

    // Zero wait states, never an error
    assign PREADY  = 1'b1;
    assign PSLVERR = 1'b0;

endmodule

`default_nettype wire

//--- logic/gpio_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_cfg.svh"

module gpio_apb_regs
    import gpio_pkg::*;
(
    input  logic                            HCLK,
    input  logic                            HRESETn,
    input  logic [`GPIO_APB_ADDR_WIDTH-1:0] PADDR,
    input  logic [`GPIO_DATA_WIDTH-1:0]     PWDATA,
    input  logic                            PWRITE,
    input  logic                            PSEL,
    input  logic                            PENABLE,
    output logic [`GPIO_DATA_WIDTH-1:0]     PRDATA,
    input  pad_vec_t                        padin,
    output pad_vec_t                        gpio_out,
    output pad_vec_t                        gpio_dir,
    gpio_irq_if.regs                        irq
);

    localparam int HALF = `GPIO_PAD_NUM / 2;

    reg_idx_t      reg_idx;
    logic          apb_write;
    logic          apb_read;

    pad_vec_t      dir_q;
    pad_vec_t      en_q;
    pad_vec_t      out_q;
    pad_vec_t      inten_q;
    int_type_vec_t int_type_q;

    assign reg_idx   = PADDR[6:2];
    assign apb_write = PSEL & PENABLE & PWRITE;   // Access phase only
    assign apb_read  = PSEL & PENABLE & ~PWRITE;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            dir_q   <= '0;
            en_q    <= '0;
            out_q   <= '0;
            inten_q <= '0;
            for (int i = 0; i < `GPIO_PAD_NUM; i++)
                int_type_q[i] <= INT_FALL;
        end
        else if (apb_write)
        begin
            case (reg_idx)
                `GPIO_REG_PADDIR:
                    dir_q <= PWDATA;
                `GPIO_REG_GPIOEN:
                    en_q <= PWDATA;
                `GPIO_REG_PADOUT:
                    out_q <= PWDATA;
                `GPIO_REG_PADOUTSET:
                    out_q <= out_q | PWDATA;
                `GPIO_REG_PADOUTCLR:
                    out_q <= out_q & ~PWDATA;   // Ones in the data clear pads
                `GPIO_REG_INTEN:
                    inten_q <= PWDATA;
                `GPIO_REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < HALF; i++)
                        int_type_q[i] <= int_type_e'(PWDATA[2*i +: 2]);
                end
                `GPIO_REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < HALF; i++)
                        int_type_q[i+HALF] <= int_type_e'(PWDATA[2*i +: 2]);
                end
                default:
                    ;   // PADIN and INTSTATUS are read only
            endcase
        end
    end

    always_comb
    begin
        PRDATA = '0;
        if (apb_read)
        begin
            case (reg_idx)
                `GPIO_REG_PADDIR:
                    PRDATA = dir_q;
                `GPIO_REG_GPIOEN:
                    PRDATA = en_q;
                `GPIO_REG_PADIN:
                    PRDATA = padin;
                `GPIO_REG_PADOUT:
                    PRDATA = out_q;
                `GPIO_REG_INTEN:
                    PRDATA = inten_q;
                `GPIO_REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < HALF; i++)
                        PRDATA[2*i +: 2] = int_type_q[i];
                end
                `GPIO_REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < HALF; i++)
                        PRDATA[2*i +: 2] = int_type_q[i+HALF];
                end
                `GPIO_REG_INTSTATUS:
                    PRDATA = irq.status;
                default:
                    PRDATA = '0;   // Set/clear and unmapped words
            endcase
        end
    end

    // Status is cleared at the edge that ends this read
    assign irq.status_clr = apb_read && (reg_idx == `GPIO_REG_INTSTATUS);

    assign irq.inten    = inten_q;
    assign irq.gpio_en  = en_q;
    assign irq.int_type = int_type_q;

    assign gpio_out = out_q;
    assign gpio_dir = dir_q;

endmodule

`default_nettype wire

//--- logic/gpio_input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_input_sync
    import gpio_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,
    input  pad_vec_t gpio_in,
    output pad_vec_t sync_in,
    output pad_vec_t prev_in
);

    pad_vec_t sync0_q;
    pad_vec_t sync1_q;
    pad_vec_t prev_q;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync0_q <= '0;
            sync1_q <= '0;
            prev_q  <= '0;
        end
        else
        begin
            sync0_q <= gpio_in;   // Metastability stage
            sync1_q <= sync0_q;
            prev_q  <= sync1_q;   // One sample older, for edges
        end
    end

    assign sync_in = sync1_q;
    assign prev_in = prev_q;

endmodule

`default_nettype wire

//--- logic/gpio_irq_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gpio_irq_if
    import gpio_pkg::*;
();

    pad_vec_t      inten;
    pad_vec_t      gpio_en;
    int_type_vec_t int_type;
    logic          status_clr;   // Strobe during INTSTATUS read access
    pad_vec_t      status;

    modport regs (
        output inten,
        output gpio_en,
        output int_type,
        output status_clr,
        input  status
    );

    modport irq (
        input  inten,
        input  gpio_en,
        input  int_type,
        input  status_clr,
        output status
    );

endinterface

`default_nettype wire

//--- logic/gpio_irq_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_cfg.svh"

module gpio_irq_unit
    import gpio_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,
    input  pad_vec_t sync_in,
    input  pad_vec_t prev_in,
    gpio_irq_if.irq  irq,
    output logic     interrupt
);

    pad_vec_t rise;
    pad_vec_t fall;
    pad_vec_t type_hit;
    pad_vec_t event_vec;
    pad_vec_t status_q;

    assign rise = sync_in & ~prev_in;
    assign fall = ~sync_in & prev_in;

    always_comb
    begin
        for (int i = 0; i < `GPIO_PAD_NUM; i++)
        begin
            case (irq.int_type[i])
                INT_FALL: type_hit[i] = fall[i];
                INT_RISE: type_hit[i] = rise[i];
                INT_BOTH: type_hit[i] = rise[i] | fall[i];
                default:  type_hit[i] = 1'b0;   // INT_NONE
            endcase
        end
    end

    assign event_vec = type_hit & irq.inten & irq.gpio_en;
    assign interrupt = |event_vec;

    // New events take priority over a clear-on-read
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            status_q <= '0;
        else if (interrupt)
            status_q <= status_q | event_vec;
        else if (irq.status_clr)
            status_q <= '0;
    end

    assign irq.status = status_q;

endmodule

`default_nettype wire

//--- logic/gpio_pkg.sv
`default_nettype none

`include "gpio_cfg.svh"

package gpio_pkg;

    typedef logic [`GPIO_PAD_NUM-1:0] pad_vec_t;

    typedef enum logic [1:0] {
        INT_FALL = 2'b00,
        INT_RISE = 2'b01,
        INT_BOTH = 2'b10,
        INT_NONE = 2'b11
    } int_type_e;

    typedef int_type_e [`GPIO_PAD_NUM-1:0] int_type_vec_t;   // Two bits per pad

    typedef logic [4:0] reg_idx_t;

endpackage

`default_nettype wire

//--- src.f
+incdir+include
logic/gpio_pkg.sv
logic/gpio_irq_if.sv
logic/gpio_input_sync.sv
logic/gpio_irq_unit.sv
logic/gpio_apb_regs.sv
logic/apb_gpio.sv
verification/apb_gpio_props.sv
verification/apb_gpio_tb.sv

//--- verification/apb_gpio_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_cfg.svh"

module apb_gpio_props
    import gpio_pkg::*;
(
    input logic                        HCLK,
    input logic                        HRESETn,
    input logic                        PSEL,
    input logic                        PENABLE,
    input logic                        PWRITE,
    input logic [`GPIO_DATA_WIDTH-1:0] PRDATA,
    input logic                        PREADY,
    input logic                        PSLVERR,
    input pad_vec_t                    gpio_in,
    input pad_vec_t                    gpio_in_sync,
    input logic                        interrupt,
    input pad_vec_t                    status
);

    no_wait_no_error: assert property (@(posedge HCLK) disable iff (!HRESETn)
        PREADY && !PSLVERR)
        else $error("PREADY or PSLVERR left its fixed level");

    // Read data only during a read access phase
    prdata_idle_zero: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !(PSEL && PENABLE && !PWRITE) |-> PRDATA == '0)
        else $error("PRDATA not zero outside a read access");

    sync_two_cycles: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $past(HRESETn, 2) |-> gpio_in_sync == $past(gpio_in, 2))
        else $error("gpio_in_sync is not gpio_in delayed by two clocks");

    irq_sets_status: assert property (@(posedge HCLK) disable iff (!HRESETn)
        interrupt |=> status != '0)
        else $error("interrupt without a status bit at the next edge");

endmodule

`default_nettype wire

//--- verification/apb_gpio_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_cfg.svh"

module apb_gpio_tb
    import gpio_pkg::*;
();

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_PADS} op_e;

    typedef struct {
        op_e         op;
        reg_idx_t    idx;
        logic [31:0] data;
        logic [31:0] exp;   // gpio_out/gpio_dir, PRDATA, or expected irq pulse
    } entry_t;

    logic                            HCLK;
    logic                            HRESETn;
    logic [`GPIO_APB_ADDR_WIDTH-1:0] PADDR;
    logic [`GPIO_DATA_WIDTH-1:0]     PWDATA;
    logic                            PWRITE;
    logic                            PSEL;
    logic                            PENABLE;
    logic [`GPIO_DATA_WIDTH-1:0]     PRDATA;
    logic                            PREADY;
    logic                            PSLVERR;
    pad_vec_t                        gpio_in;
    pad_vec_t                        gpio_in_sync;
    pad_vec_t                        gpio_out;
    pad_vec_t                        gpio_dir;
    logic                            interrupt;

    entry_t      stim_q[$];
    logic [31:0] lfsr_state;
    logic        built;
    int          irq_count;
    int          error_count;
    int          pass_count;
    int          fail_count;

    // Reference state while the table is built
    logic [31:0] model_out;
    logic [31:0] model_pads;
    logic [31:0] model_status;
    logic [31:0] cfg_en;
    logic [31:0] cfg_inten;
    logic [63:0] cfg_type;

    apb_gpio apb_gpio_inst (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .PADDR        (PADDR),
        .PWDATA       (PWDATA),
        .PWRITE       (PWRITE),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PRDATA       (PRDATA),
        .PREADY       (PREADY),
        .PSLVERR      (PSLVERR),
        .gpio_in      (gpio_in),
        .gpio_in_sync (gpio_in_sync),
        .gpio_out     (gpio_out),
        .gpio_dir     (gpio_dir),
        .interrupt    (interrupt)
    );

    bind apb_gpio apb_gpio_props apb_gpio_props_inst (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PWRITE       (PWRITE),
        .PRDATA       (PRDATA),
        .PREADY       (PREADY),
        .PSLVERR      (PSLVERR),
        .gpio_in      (gpio_in),
        .gpio_in_sync (gpio_in_sync),
        .interrupt    (interrupt),
        .status       (irq_bus.status)
    );

    always #20 HCLK = ~HCLK;

    always @(negedge HCLK)
        if (HRESETn && interrupt)
            irq_count <= irq_count + 1;   // Counts single-cycle interrupt pulses

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] next_random();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // Type 00 fall, 01 rise, 10 both, 11 never
    function automatic logic [31:0] qualified_edges(input logic [31:0] old_pads,
            input logic [31:0] new_pads, input logic [31:0] en, input logic [31:0] ien,
            input logic [63:0] types);
        logic [31:0] hits;
        logic        rise;
        logic        fall;
        hits = '0;
        for (int i = 0; i < 32; i++)
        begin
            rise = new_pads[i] & ~old_pads[i];
            fall = old_pads[i] & ~new_pads[i];
            case (types[2*i +: 2])
                2'b00:   hits[i] = fall;
                2'b01:   hits[i] = rise;
                2'b10:   hits[i] = rise | fall;
                default: hits[i] = 1'b0;
            endcase
        end
        return hits & en & ien;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic add_entry(input op_e op, input reg_idx_t idx, input logic [31:0] data,
            input logic [31:0] exp);
        entry_t e;
        e.op   = op;
        e.idx  = idx;
        e.data = data;
        e.exp  = exp;
        stim_q.push_back(e);
    endtask

    task automatic add_read(input reg_idx_t idx, input logic [31:0] exp);
        add_entry(OP_READ, idx, '0, exp);
    endtask

    task automatic add_status_read();
        add_read(`GPIO_REG_INTSTATUS, model_status);
        model_status = '0;   // Cleared by the read
    endtask

    task automatic add_write(input reg_idx_t idx, input logic [31:0] data);
        case (idx)
            `GPIO_REG_GPIOEN:     cfg_en = data;
            `GPIO_REG_INTEN:      cfg_inten = data;
            `GPIO_REG_INTTYPE_LO: cfg_type[31:0] = data;
            `GPIO_REG_INTTYPE_HI: cfg_type[63:32] = data;
            `GPIO_REG_PADOUT:     model_out = data;
            `GPIO_REG_PADOUTSET:  model_out = model_out | data;
            `GPIO_REG_PADOUTCLR:  model_out = model_out & ~data;
            default:              ;
        endcase
        if (idx inside {`GPIO_REG_PADOUT, `GPIO_REG_PADOUTSET, `GPIO_REG_PADOUTCLR})
            add_entry(OP_WRITE, idx, data, model_out);
        else
            add_entry(OP_WRITE, idx, data, data);
    endtask

    task automatic add_pads(input logic [31:0] data);
        logic [31:0] edges;
        edges = qualified_edges(model_pads, data, cfg_en, cfg_inten, cfg_type);
        model_status = model_status | edges;
        model_pads   = data;
        add_entry(OP_PADS, '0, data, 32'(|edges));
    endtask

    task automatic build_table();
        for (int r = 0; r <= 9; r++)
            add_read(reg_idx_t'(r), '0);
        add_pads(32'h5a3c_96e1);   // No interrupts enabled yet
        add_read(`GPIO_REG_PADIN, model_pads);
        add_status_read();
        add_pads(32'h0000_0000);
        add_read(`GPIO_REG_PADIN, model_pads);
        add_write(`GPIO_REG_PADDIR, 32'h0f0f_a5a5);
        add_read(`GPIO_REG_PADDIR, 32'h0f0f_a5a5);
        add_write(`GPIO_REG_GPIOEN, 32'h1234_5678);
        add_read(`GPIO_REG_GPIOEN, cfg_en);
        add_write(`GPIO_REG_INTEN, 32'h8765_4321);
        add_read(`GPIO_REG_INTEN, cfg_inten);
        add_write(`GPIO_REG_INTTYPE_LO, 32'hdead_beef);
        add_read(`GPIO_REG_INTTYPE_LO, cfg_type[31:0]);
        add_write(`GPIO_REG_INTTYPE_HI, 32'h0bad_f00d);
        add_read(`GPIO_REG_INTTYPE_HI, cfg_type[63:32]);
        add_write(`GPIO_REG_PADOUT, next_random());
        add_read(`GPIO_REG_PADOUT, model_out);
        add_read(5'd10, '0);
        add_read(5'd31, '0);
        for (int k = 0; k < 2; k++)
        begin
            add_write(`GPIO_REG_PADOUTSET, next_random());
            add_read(`GPIO_REG_PADOUT, model_out);
            add_write(`GPIO_REG_PADOUTCLR, next_random());
            add_read(`GPIO_REG_PADOUT, model_out);
        end
        // Pad i gets type i mod 4; pads 28-29 disabled, 30-31 masked
        add_write(`GPIO_REG_GPIOEN, 32'hcfff_ffff);
        add_write(`GPIO_REG_INTEN, 32'h3fff_ffff);
        add_write(`GPIO_REG_INTTYPE_LO, 32'he4e4_e4e4);
        add_write(`GPIO_REG_INTTYPE_HI, 32'he4e4_e4e4);
        add_status_read();
        add_pads(32'hffff_ffff);
        add_status_read();
        add_status_read();
        add_pads(32'h0000_0000);
        add_status_read();
        add_status_read();
        add_pads(32'h0000_ff00);
        add_status_read();
        add_pads(32'h8000_ff88);   // Only never-type and masked pads rise
        add_status_read();
        add_pads(32'h3000_0000);
        add_status_read();
        add_status_read();
    endtask

    task automatic apb_write(input reg_idx_t idx, input logic [31:0] data);
        @(posedge HCLK);
        PADDR   <= {{(`GPIO_APB_ADDR_WIDTH-7){1'b0}}, idx, 2'b00};
        PWDATA  <= data;
        PWRITE  <= 1'b1;
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        @(posedge HCLK);
        PENABLE <= 1'b1;
        @(posedge HCLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b0;
    endtask

    task automatic apb_read(input reg_idx_t idx, output logic [31:0] data);
        @(posedge HCLK);
        PADDR   <= {{(`GPIO_APB_ADDR_WIDTH-7){1'b0}}, idx, 2'b00};
        PWRITE  <= 1'b0;
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        @(posedge HCLK);
        PENABLE <= 1'b1;
        @(negedge HCLK);
        data = PRDATA;
        @(posedge HCLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] rd;
        int          irq_start;
        case (e.op)
            OP_WRITE:
            begin
                apb_write(e.idx, e.data);
                @(negedge HCLK);
                if (e.idx == `GPIO_REG_PADDIR)
                    check_value("gpio_dir", gpio_dir, e.exp);
                else if (e.idx inside {`GPIO_REG_PADOUT, `GPIO_REG_PADOUTSET,
                                       `GPIO_REG_PADOUTCLR})
                    check_value("gpio_out", gpio_out, e.exp);
            end
            OP_READ:
            begin
                apb_read(e.idx, rd);
                check_value("PRDATA", rd, e.exp);
            end
            default:
            begin
                irq_start = irq_count;
                @(posedge HCLK);
                gpio_in <= e.data;
                repeat (4) @(posedge HCLK);
                @(negedge HCLK);
                check_value("gpio_in_sync", gpio_in_sync, e.data);
                check_value("interrupt", 32'(irq_count != irq_start), e.exp);
            end
        endcase
    endtask

    initial
    begin
        int errors_before;
        HCLK         = 1'b0;
        HRESETn      = 1'b0;
        PADDR        = '0;
        PWDATA       = '0;
        PWRITE       = 1'b0;
        PSEL         = 1'b0;
        PENABLE      = 1'b0;
        gpio_in      = '0;
        irq_count    = 0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        lfsr_state   = 32'hbcf1;
        model_out    = '0;
        model_pads   = '0;
        model_status = '0;
        cfg_en       = '0;
        cfg_inten    = '0;
        cfg_type     = '0;
        built        = 1'b0;
        build_table();
        built = 1'b1;
        repeat (2) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(negedge HCLK);
        check_value("gpio_out", gpio_out, '0);
        check_value("gpio_dir", gpio_dir, '0);
        check_value("interrupt", 32'(interrupt), '0);
        foreach (stim_q[n])
        begin
            errors_before = error_count;
            run_entry(stim_q[n]);
            if (error_count == errors_before)
                pass_count++;
            else
                fail_count++;
            $display("Entry %0d %s idx %0d: %s", n, stim_q[n].op.name(), stim_q[n].idx,
                     (error_count == errors_before) ? "ok" : "FAILED");
        end
        $display("Done: %0d entries passed, %0d entries failed, %0d mismatches",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // 12 cycles of 40 ns per entry
    initial
    begin
        wait (built);
        #(stim_q.size() * 12 * 40);
        $display("Watchdog expired before the stimulus table finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
